// ==== src/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// First fetch address and base of the ROM window
`define FETCH_RESET_VECTOR 32'h2000

// ROM window size in words
`define FETCH_ROM_WORDS 32

// Cycles from an accepted execute command to its response
`define FETCH_MEM_LATENCY 3

// Flush length, also used for the clear after reset
`define FETCH_FLUSH_CYCLES 4

// addi x0, x0, 0
`define FETCH_INSTR_NOP 32'h0000_0013

`endif

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // Address and instruction word
    typedef logic [31:0] word_t;

    // Commands from fetch to the instruction cache
    typedef enum logic [3:0] {
        cache_cmd_none      = 4'd0,
        cache_cmd_execute   = 4'd1,
        cache_cmd_flush_all = 4'd2
    } cache_cmd_t;

    // Responses from the instruction cache
    typedef enum logic [3:0] {
        cache_resp_idle         = 4'd0,
        cache_resp_wait         = 4'd1,
        cache_resp_done         = 4'd2,
        cache_resp_access_fault = 4'd3,
        cache_resp_misaligned   = 4'd4,
        // Only reachable with an MMU
        cache_resp_page_fault   = 4'd5
    } cache_resp_t;

    // Low bits of mcause
    typedef logic [3:0] exc_code_t;

    localparam exc_code_t exc_misaligned_fetch = 4'd0;
    localparam exc_code_t exc_access_fault     = 4'd1;
    localparam exc_code_t exc_timer_interrupt  = 4'd7;
    localparam exc_code_t exc_external_interrupt = 4'd11;
    localparam exc_code_t exc_page_fault       = 4'd12;

endpackage

// ==== src/instr_mem_port.sv ====
`include "fetch_macros.svh"

module instr_mem_port (
    input  logic                   clk,
    input  logic                   reseted,
    input  fetch_pkg::cache_cmd_t  c_cmd,
    input  fetch_pkg::word_t       c_address,
    output fetch_pkg::cache_resp_t c_response,
    output fetch_pkg::word_t       c_load_data,
    output logic                   c_reset_done
);

    localparam int unsigned rom_idx_w = $clog2(`FETCH_ROM_WORDS);

    typedef enum logic [2:0] {
        mem_clearing,
        mem_idle,
        mem_busy_fetch,
        mem_busy_flush,
        mem_respond
    } mem_state_t;

    mem_state_t             state;
    logic [3:0]             count;
    fetch_pkg::word_t       addr_q;
    fetch_pkg::word_t       cmd_offset;
    fetch_pkg::word_t       fetch_offset;
    logic [rom_idx_w-1:0]   rom_index;
    logic                   accept;
    logic                   in_window;

    fetch_pkg::word_t rom [0:`FETCH_ROM_WORDS-1];

    initial begin
        $readmemh("rom_image.hex", rom);
    end

    // Commands are only taken once the previous one has answered
    assign accept = (state == mem_idle) || (state == mem_respond);

    // Unsigned wrap also rejects addresses below the window
    assign cmd_offset   = c_address - `FETCH_RESET_VECTOR;
    assign in_window    = cmd_offset < fetch_pkg::word_t'(`FETCH_ROM_WORDS * 4);
    assign fetch_offset = addr_q - `FETCH_RESET_VECTOR;
    assign rom_index    = fetch_offset[rom_idx_w+1:2];

    always_ff @(posedge clk) begin
        if (reseted) begin
            state        <= mem_clearing;
            count        <= 4'(`FETCH_FLUSH_CYCLES - 1);
            c_response   <= fetch_pkg::cache_resp_idle;
            c_reset_done <= 1'b0;
        end else begin
            case (state)
                mem_clearing: begin
                    if (count == 4'd0) begin
                        c_reset_done <= 1'b1;
                        state        <= mem_idle;
                    end else begin
                        count <= count - 4'd1;
                    end
                end
                mem_busy_fetch, mem_busy_flush: begin
                    if (count == 4'd0) begin
                        c_response <= fetch_pkg::cache_resp_done;
                        state      <= mem_respond;
                    end else begin
                        count <= count - 4'd1;
                    end
                end
                default: begin
                    if (c_cmd == fetch_pkg::cache_cmd_execute) begin
                        if (c_address[1:0] != 2'b00) begin
                            c_response <= fetch_pkg::cache_resp_misaligned;
                            state      <= mem_respond;
                        end else if (!in_window) begin
                            c_response <= fetch_pkg::cache_resp_access_fault;
                            state      <= mem_respond;
                        end else begin
                            c_response <= fetch_pkg::cache_resp_wait;
                            count      <= 4'(`FETCH_MEM_LATENCY - 2);
                            state      <= mem_busy_fetch;
                        end
                    end else if (c_cmd == fetch_pkg::cache_cmd_flush_all) begin
                        c_response <= fetch_pkg::cache_resp_wait;
                        count      <= 4'(`FETCH_FLUSH_CYCLES - 1);
                        state      <= mem_busy_flush;
                    end else begin
                        c_response <= fetch_pkg::cache_resp_idle;
                        state      <= mem_idle;
                    end
                end
            endcase
        end
    end

    // Address held for the whole wait, word read on its last cycle
    always_ff @(posedge clk) begin
        if (accept && c_cmd == fetch_pkg::cache_cmd_execute) begin
            addr_q <= c_address;
        end
        if (state == mem_busy_fetch && count == 4'd0) begin
            c_load_data <= rom[rom_index];
        end
    end

endmodule

// ==== src/fetch_stage.sv ====
`include "fetch_macros.svh"

module fetch_stage (
    input  logic                   clk,
    input  logic                   reseted,
    input  fetch_pkg::word_t       mtvec,
    input  fetch_pkg::cache_resp_t c_response,
    input  logic                   c_reset_done,
    input  fetch_pkg::word_t       c_load_data,
    input  logic                   irq_timer,
    input  logic                   irq_exti,
    input  logic                   e2f_ready,
    input  logic                   e2f_exc_start,
    input  logic                   e2f_flush,
    input  logic                   e2f_branchtaken,
    input  fetch_pkg::word_t       e2f_branchtarget,
    output fetch_pkg::cache_cmd_t  c_cmd,
    output fetch_pkg::word_t       c_address,
    output fetch_pkg::word_t       f2e_instr,
    output fetch_pkg::word_t       f2e_pc,
    output logic                   f2e_exc_start,
    output fetch_pkg::exc_code_t   f2e_cause,
    output logic                   f2e_cause_interrupt
);

    typedef enum logic [1:0] {
        st_reset_pending,
        st_running,
        st_flushing,
        st_after_flush
    } fetch_state_t;

    fetch_state_t     state;
    fetch_state_t     state_next;
    fetch_pkg::word_t pc;
    fetch_pkg::word_t next_pc;
    fetch_pkg::word_t saved_instr;

    logic cache_done;
    logic cache_wait;
    logic cache_idle;
    logic cache_error;
    logic issue;

    assign cache_done  = (c_response == fetch_pkg::cache_resp_done);
    assign cache_wait  = (c_response == fetch_pkg::cache_resp_wait);
    assign cache_idle  = (c_response == fetch_pkg::cache_resp_idle);
    assign cache_error = (c_response == fetch_pkg::cache_resp_access_fault) ||
                         (c_response == fetch_pkg::cache_resp_misaligned) ||
                         (c_response == fetch_pkg::cache_resp_page_fault);

    // A new fetch may start
    assign issue = (state == st_reset_pending) || cache_error ||
                   (e2f_ready && (cache_done || cache_idle));

    always_comb begin
        f2e_instr     = `FETCH_INSTR_NOP;
        next_pc       = pc;
        c_cmd         = fetch_pkg::cache_cmd_none;
        f2e_exc_start = 1'b0;
        state_next    = state;
        if (c_reset_done) begin
            // Fresh word, or replay of the word held under back-pressure
            if (cache_done && state != st_flushing) begin
                f2e_instr = c_load_data;
            end else if (cache_idle && state == st_running) begin
                f2e_instr = saved_instr;
            end

            if (state == st_flushing) begin
                if (cache_done) begin
                    state_next = st_after_flush;
                end else begin
                    c_cmd = fetch_pkg::cache_cmd_flush_all;
                end
            end else if (cache_wait) begin
                // Keep asking for the held pc
                c_cmd = fetch_pkg::cache_cmd_execute;
            end else if (issue) begin
                c_cmd      = fetch_pkg::cache_cmd_execute;
                state_next = st_running;
                if (state == st_reset_pending) begin
                    next_pc = `FETCH_RESET_VECTOR;
                end else if (irq_exti || irq_timer) begin
                    f2e_exc_start = 1'b1;
                    next_pc       = mtvec;
                end else if (e2f_branchtaken) begin
                    next_pc = e2f_branchtarget;
                end else if (e2f_ready && e2f_flush) begin
                    // pc stays put, resume at pc + 4 after the flush
                    c_cmd      = fetch_pkg::cache_cmd_flush_all;
                    state_next = st_flushing;
                end else if (e2f_ready && e2f_exc_start) begin
                    next_pc = mtvec;
                end else if (cache_error) begin
                    f2e_exc_start = 1'b1;
                    next_pc       = mtvec;
                end else begin
                    next_pc = pc + 32'd4;
                end
            end
        end
    end

    assign c_address = next_pc;
    assign f2e_pc    = pc;

    // Cause code, interrupts first as in the redirect order, then fetch faults
    always_comb begin
        f2e_cause           = fetch_pkg::exc_code_t'(0);
        f2e_cause_interrupt = 1'b0;
        if (!e2f_exc_start) begin
            if (irq_exti) begin
                f2e_cause           = fetch_pkg::exc_external_interrupt;
                f2e_cause_interrupt = 1'b1;
            end else if (irq_timer) begin
                f2e_cause           = fetch_pkg::exc_timer_interrupt;
                f2e_cause_interrupt = 1'b1;
            end else if (c_response == fetch_pkg::cache_resp_misaligned) begin
                f2e_cause = fetch_pkg::exc_misaligned_fetch;
            end else if (c_response == fetch_pkg::cache_resp_access_fault) begin
                f2e_cause = fetch_pkg::exc_access_fault;
            end else if (c_response == fetch_pkg::cache_resp_page_fault) begin
                f2e_cause = fetch_pkg::exc_page_fault;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            state <= st_reset_pending;
            pc    <= `FETCH_RESET_VECTOR;
        end else begin
            state <= state_next;
            pc    <= next_pc;
        end
    end

    // Last presented word, replayed while execute stalls
    always_ff @(posedge clk) begin
        saved_instr <= f2e_instr;
    end

endmodule

// ==== src/fetch_top.sv ====
module fetch_top (
    input  logic                 clk,
    input  logic                 reseted,
    input  fetch_pkg::word_t     mtvec,
    input  logic                 irq_timer,
    input  logic                 irq_exti,
    input  logic                 e2f_ready,
    input  logic                 e2f_exc_start,
    input  logic                 e2f_flush,
    input  logic                 e2f_branchtaken,
    input  fetch_pkg::word_t     e2f_branchtarget,
    output fetch_pkg::word_t     f2e_instr,
    output fetch_pkg::word_t     f2e_pc,
    output logic                 f2e_exc_start,
    output fetch_pkg::exc_code_t f2e_cause,
    output logic                 f2e_cause_interrupt
);

    // Cache port between fetch and memory
    fetch_pkg::cache_cmd_t  c_cmd;
    fetch_pkg::word_t       c_address;
    fetch_pkg::cache_resp_t c_response;
    fetch_pkg::word_t       c_load_data;
    logic                   c_reset_done;

    fetch_stage u_fetch (
        .clk                 (clk),
        .reseted             (reseted),
        .mtvec               (mtvec),
        .c_response          (c_response),
        .c_reset_done        (c_reset_done),
        .c_load_data         (c_load_data),
        .irq_timer           (irq_timer),
        .irq_exti            (irq_exti),
        .e2f_ready           (e2f_ready),
        .e2f_exc_start       (e2f_exc_start),
        .e2f_flush           (e2f_flush),
        .e2f_branchtaken     (e2f_branchtaken),
        .e2f_branchtarget    (e2f_branchtarget),
        .c_cmd               (c_cmd),
        .c_address           (c_address),
        .f2e_instr           (f2e_instr),
        .f2e_pc              (f2e_pc),
        .f2e_exc_start       (f2e_exc_start),
        .f2e_cause           (f2e_cause),
        .f2e_cause_interrupt (f2e_cause_interrupt)
    );

    instr_mem_port u_mem (
        .clk          (clk),
        .reseted      (reseted),
        .c_cmd        (c_cmd),
        .c_address    (c_address),
        .c_response   (c_response),
        .c_load_data  (c_load_data),
        .c_reset_done (c_reset_done)
    );

endmodule

// ==== sim/fetch_tb_clock.sv ====
module fetch_tb_clock (
    output logic clk
);

    // Period of 10 time units
    initial begin
        clk = 1'b0;
        forever begin
            #5;
            clk = ~clk;
        end
    end

endmodule

// ==== sim/fetch_properties.sv ====
module fetch_properties (
    input logic                   clk,
    input logic                   reseted,
    input fetch_pkg::cache_cmd_t  c_cmd,
    input fetch_pkg::word_t       c_address,
    input fetch_pkg::cache_resp_t c_response,
    input logic                   c_reset_done,
    input logic                   f2e_exc_start,
    input fetch_pkg::word_t       f2e_pc,
    input fetch_pkg::word_t       mtvec
);

    // Memory must finish its clear before the first command
    no_cmd_before_clear: assert property (@(posedge clk) disable iff (reseted)
        !c_reset_done |-> c_cmd == fetch_pkg::cache_cmd_none)
        else $error("Fetch issued a command before c_reset_done was high");

    // Traps always redirect to the vector base
    trap_goes_to_mtvec: assert property (@(posedge clk) disable iff (reseted)
        f2e_exc_start |=> f2e_pc == $past(mtvec))
        else $error("pc did not move to mtvec after f2e_exc_start");

    // Held address while the memory is busy
    addr_stable_in_wait: assert property (@(posedge clk) disable iff (reseted)
        c_response == fetch_pkg::cache_resp_wait |-> $stable(c_address))
        else $error("c_address changed while the memory answered wait");

endmodule

bind fetch_stage fetch_properties u_props (
    .clk           (clk),
    .reseted       (reseted),
    .c_cmd         (c_cmd),
    .c_address     (c_address),
    .c_response    (c_response),
    .c_reset_done  (c_reset_done),
    .f2e_exc_start (f2e_exc_start),
    .f2e_pc        (f2e_pc),
    .mtvec         (mtvec)
);

// ==== sim/fetch_tb.sv ====
`include "fetch_macros.svh"

module fetch_tb;

    localparam int               timeout_cycles = 200;
    localparam fetch_pkg::word_t mtvec_addr     = 32'h2040;

    logic                 clk;
    logic                 reseted;
    fetch_pkg::word_t     mtvec;
    logic                 irq_timer;
    logic                 irq_exti;
    logic                 e2f_ready;
    logic                 e2f_exc_start;
    logic                 e2f_flush;
    logic                 e2f_branchtaken;
    fetch_pkg::word_t     e2f_branchtarget;
    fetch_pkg::word_t     f2e_instr;
    fetch_pkg::word_t     f2e_pc;
    logic                 f2e_exc_start;
    fetch_pkg::exc_code_t f2e_cause;
    logic                 f2e_cause_interrupt;

    // Reference copy of the ROM contents
    fetch_pkg::word_t model [0:`FETCH_ROM_WORDS-1];
    fetch_pkg::word_t exp_pc;
    logic [31:0]      rng;
    int               checks;
    int               errors;
    int               timeouts;
    int               waited;

    fetch_tb_clock u_clock (
        .clk (clk)
    );

    fetch_top DUT (
        .clk                 (clk),
        .reseted             (reseted),
        .mtvec               (mtvec),
        .irq_timer           (irq_timer),
        .irq_exti            (irq_exti),
        .e2f_ready           (e2f_ready),
        .e2f_exc_start       (e2f_exc_start),
        .e2f_flush           (e2f_flush),
        .e2f_branchtaken     (e2f_branchtaken),
        .e2f_branchtarget    (e2f_branchtarget),
        .f2e_instr           (f2e_instr),
        .f2e_pc              (f2e_pc),
        .f2e_exc_start       (f2e_exc_start),
        .f2e_cause           (f2e_cause),
        .f2e_cause_interrupt (f2e_cause_interrupt)
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Cycle where execute takes a real word, fresh or replayed
    task automatic consume(input logic exp_exc, input fetch_pkg::exc_code_t exp_cause,
                           input logic exp_intr);
        fetch_pkg::word_t offset;
        int               n;
        n = 0;
        @(negedge clk);
        while (!(e2f_ready && f2e_instr != `FETCH_INSTR_NOP)) begin
            if (n == timeout_cycles) begin
                $display("Timeout: execute took no instruction within %0d cycles", n);
                timeouts++;
                finish_run();
            end
            @(negedge clk);
            n++;
        end
        waited = n;
        offset = exp_pc - `FETCH_RESET_VECTOR;
        check_value("f2e_pc", f2e_pc, exp_pc);
        check_value("f2e_instr", f2e_instr, model[offset[6:2]]);
        check_value("f2e_exc_start", 32'(f2e_exc_start), 32'(exp_exc));
        if (exp_exc) begin
            check_value("f2e_cause", 32'(f2e_cause), 32'(exp_cause));
            check_value("f2e_cause_interrupt", 32'(f2e_cause_interrupt), 32'(exp_intr));
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic expect_fault(input fetch_pkg::exc_code_t exp_cause);
        int n;
        n = 0;
        @(negedge clk);
        while (!f2e_exc_start) begin
            if (n == timeout_cycles) begin
                $display("Timeout: fetch fault never raised f2e_exc_start");
                timeouts++;
                finish_run();
            end
            @(negedge clk);
            n++;
        end
        check_value("f2e_cause", 32'(f2e_cause), 32'(exp_cause));
        check_value("f2e_cause_interrupt", 32'(f2e_cause_interrupt), 32'd0);
        check_value("f2e_instr", f2e_instr, `FETCH_INSTR_NOP);
    endtask

    task automatic consume_with_branch(input fetch_pkg::word_t target);
        @(posedge clk);
        e2f_branchtaken  <= 1'b1;
        e2f_branchtarget <= target;
        consume(1'b0, '0, 1'b0);
        @(posedge clk);
        e2f_branchtaken <= 1'b0;
    endtask

    task automatic test_reset_sequential();
        repeat (16) @(posedge clk);
        reseted <= 1'b0;
        @(negedge clk);
        check_value("f2e_instr", f2e_instr, `FETCH_INSTR_NOP);
        check_value("f2e_exc_start", 32'(f2e_exc_start), 32'd0);
        exp_pc = `FETCH_RESET_VECTOR;
        repeat (6) consume(1'b0, '0, 1'b0);
    endtask

    task automatic test_back_pressure();
        logic stop;
        stop = 1'b0;
        fork
            begin
                repeat (12) consume(1'b0, '0, 1'b0);
                stop = 1'b1;
            end
            begin
                // Ready low in roughly one cycle of four
                while (!stop) begin
                    @(posedge clk);
                    rng = next_random(rng);
                    e2f_ready <= stop ? 1'b1 : (rng[4] | rng[11]);
                end
            end
        join
    endtask

    task automatic test_branch_flush();
        consume_with_branch(32'h2008);
        exp_pc = 32'h2008;
        e2f_flush <= 1'b1;
        consume(1'b0, '0, 1'b0);
        @(posedge clk);
        e2f_flush <= 1'b0;
        consume(1'b0, '0, 1'b0);
        checks++;
        assert (waited >= `FETCH_FLUSH_CYCLES + 2) else begin
            errors++;
            $display("Instruction delivered %0d cycles after the flush, before it could end",
                     waited);
        end
    endtask

    task automatic test_interrupts();
        @(posedge clk);
        irq_exti  <= 1'b1;
        irq_timer <= 1'b1;
        consume(1'b1, fetch_pkg::exc_external_interrupt, 1'b1);
        @(posedge clk);
        irq_exti <= 1'b0;
        // Timer still pending, taken at the handler entry
        exp_pc = mtvec_addr;
        consume(1'b1, fetch_pkg::exc_timer_interrupt, 1'b1);
        @(posedge clk);
        irq_timer <= 1'b0;
        exp_pc = mtvec_addr;
        consume(1'b0, '0, 1'b0);
    endtask

    task automatic fault_to_mtvec(input fetch_pkg::word_t target,
                                  input fetch_pkg::exc_code_t cause);
        consume_with_branch(target);
        expect_fault(cause);
        exp_pc = mtvec_addr;
        consume(1'b0, '0, 1'b0);
    endtask

    task automatic test_faults();
        fault_to_mtvec(32'h2042, fetch_pkg::exc_misaligned_fetch);
        fault_to_mtvec(32'h3000, fetch_pkg::exc_access_fault);
    endtask

    initial begin
        reseted          = 1'b1;
        mtvec            = mtvec_addr;
        irq_timer        = 1'b0;
        irq_exti         = 1'b0;
        e2f_ready        = 1'b1;
        e2f_exc_start    = 1'b0;
        e2f_flush        = 1'b0;
        e2f_branchtaken  = 1'b0;
        e2f_branchtarget = '0;
        rng              = 32'h7dd2_06fe;
        checks           = 0;
        errors           = 0;
        timeouts         = 0;
        waited           = 0;
        exp_pc           = `FETCH_RESET_VECTOR;
        $readmemh("rom_image.hex", model);
        test_reset_sequential();
        test_back_pressure();
        test_branch_flush();
        test_interrupts();
        test_faults();
        finish_run();
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/fetch_pkg.sv
src/instr_mem_port.sv
src/fetch_stage.sv
src/fetch_top.sv
sim/fetch_tb_clock.sv
sim/fetch_properties.sv
sim/fetch_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module fetch_tb -f filelist.f -o fetch_tb

run: compile
	./obj_dir/fetch_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== rom_image.hex ====
// One 32-bit instruction word per line, from the reset vector upward
00000093
00100113
00200193
00300213
00400293
00500313
00600393
00700413
00800493
00900513
00A00593
00B00613
00C00693
00D00713
00E00793
00F00813
01000893
01100913
01200993
01300A13
01400A93
01500B13
01600B93
01700C13
01800C93
01900D13
01A00D93
01B00E13
01C00E93
01D00F13
01E00F93
01F00093
